/* uart_ctl.f */
+incdir+src
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_ser.sv
src/uart_des.sv
src/uart_regs.sv
src/uart_ctl.sv
testbench/uart_ctl_chk.sv
testbench/uart_ctl_tb.sv

/* testbench/uart_ctl_tb.sv */
// Directed testbench for the UART controller, drives the register bus and rxd, checks txd
`timescale 1ns/1ps
`include "uart_ctl_defines.svh"

module uart_ctl_tb import uart_pkg::*; ();

  localparam int CLK_NS  = 100;
  localparam int DRV_DLY = 10;   // Input drive after rising edge
  // Test sizes and bit timing
  localparam int T3_FRM  = 6;
  localparam int T3_BDR  = 5;
  localparam int T4_FRM  = 4;
  localparam int RX_BDR  = 7;
  localparam int RX_SMP  = 3;
  localparam int T5_BDR  = 19;   // Slow enough to fill the TX FIFO
  localparam int T5_WR   = `UART_FIFO_SZ + 2;
  localparam int T5_TX   = `UART_FIFO_SZ + 1;  // FIFO depth plus the byte in the serializer
  localparam int T5_RX   = 3;
  localparam int T5_TXTH = 4;
  localparam int T5_RXTH = 2;
  // Frames times ten bits, the extra TX frame is the idle check
  localparam int WDOG_NS = (T3_FRM * (T3_BDR + 1) + (T4_FRM + T5_RX) * (RX_BDR + 1)
                          + (T5_TX + 1) * (T5_BDR + 1)) * 10 * CLK_NS + 100_000;
  localparam bus_dat_t BDR_MASK = (32'd1 << `UART_BW) - 1;
  localparam bus_dat_t CNT_MASK = (32'd1 << `UART_FIFO_CW) - 1;

  logic        tcb;
  logic        rst;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        rxd;
  logic        txd;
  logic        irq_tx;
  logic        irq_rx;
  logic [31:0] rng = 32'hf143138a;

  uart_ctl UUT (.tcb, .rst, .req, .rsp, .rxd, .txd, .irq_tx, .irq_rx);

  always #(CLK_NS / 2) tcb = ~tcb;

  //////////////////////////////////////////////////////////////////////
  // Reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_dat(input string name, input uart_dat_t got, input uart_dat_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_cnt(input string name, input uart_cnt_t got, input uart_cnt_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input bus_dat_t got, input bus_dat_t exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  // Bound checker watch
  always @(posedge tcb) begin
    if (UUT.chk.fail_cnt != 0) abort_run("Bound checker reported an assertion failure");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic uart_dat_t rand_byte();
    rng = xorshift32(rng);
    return rng[`UART_DW-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus and serial drivers
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input bus_adr_t adr, input bus_dat_t dat);
    @(posedge tcb);
    #DRV_DLY;
    req = '{vld: 1'b1, wen: 1'b1, adr: adr, wdt: dat};
    @(posedge tcb);  // Transfer
    #DRV_DLY;
    req.vld = 1'b0;
  endtask

  task automatic bus_read(input bus_adr_t adr, output bus_dat_t dat);
    @(posedge tcb);
    #DRV_DLY;
    req = '{vld: 1'b1, wen: 1'b0, adr: adr, wdt: '0};
    @(posedge tcb);
    #DRV_DLY;
    req.vld = 1'b0;
    // Response is registered, valid in this cycle only
    if (rsp.vld !== 1'b1) abort_run("No read response in the cycle after the request");
    dat = rsp.rdt;
  endtask

  // Start, data LSB first, stop, then one idle bit
  task automatic send_frame(input uart_dat_t b, input int bit_cyc);
    logic [9:0] frm;
    frm = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge tcb);
      #DRV_DLY;
      rxd = frm[i];
      repeat (bit_cyc - 1) @(posedge tcb);
    end
    repeat (bit_cyc) @(posedge tcb);
  endtask

  task automatic recv_frame(input int bit_cyc, output uart_dat_t b);
    int n;
    n = 0;
    do begin  // Hunt for the start bit
      @(posedge tcb);
      #DRV_DLY;
      n++;
      if (n > 12 * bit_cyc) abort_run("No start bit seen on txd");
    end while (txd !== 1'b0);
    #(bit_cyc * CLK_NS / 2 + 15);  // Middle of start bit, clear of edges
    check_bit("txd start", txd, 1'b0);
    for (int i = 0; i < `UART_DW; i++) begin
      #(bit_cyc * CLK_NS);
      b[i] = txd;
    end
    #(bit_cyc * CLK_NS);
    check_bit("txd stop", txd, 1'b1);
  endtask

  // Level rises after the stop bit, polled with a bound
  task automatic poll_rx_level(input uart_cnt_t exp);
    bus_dat_t w;
    int       n;
    n = 0;
    do begin
      bus_read(`UART_ADR_RX_CNT, w);
      n++;
    end while ((uart_cnt_t'(w) != exp) && (n < 32));
    check_cnt("rx_cnt", uart_cnt_t'(w), exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    bus_dat_t w;
    bus_read(`UART_ADR_TX_BDR, w);
    check_word("tx_bdr", w, `UART_BDR_RST);
    bus_read(`UART_ADR_RX_BDR, w);
    check_word("rx_bdr", w, `UART_BDR_RST);
    bus_read(`UART_ADR_RX_SMP, w);
    check_word("rx_smp", w, `UART_SMP_RST);
    bus_read(`UART_ADR_TX_IRQ, w);
    check_word("tx_irq", w, `UART_IRQ_RST);
    bus_read(`UART_ADR_RX_IRQ, w);
    check_word("rx_irq", w, `UART_IRQ_RST);
    bus_read(`UART_ADR_TX_CNT, w);
    check_cnt("tx_cnt", uart_cnt_t'(w), '0);
    bus_read(`UART_ADR_RX_CNT, w);
    check_cnt("rx_cnt", uart_cnt_t'(w), '0);
    check_bit("irq_tx", irq_tx, 1'b0);
    check_bit("irq_rx", irq_rx, 1'b0);
    check_bit("txd", txd, 1'b1);
  endtask

  task automatic test_register_access();
    bus_dat_t w;
    bus_write(`UART_ADR_TX_BDR, 32'hdead_0005);
    bus_write(`UART_ADR_RX_BDR, 32'h1234_abcd);
    bus_write(`UART_ADR_RX_SMP, 32'hffff_0102);
    bus_write(`UART_ADR_TX_IRQ, 32'hffff_ffe4);
    bus_write(`UART_ADR_RX_IRQ, 32'h0000_003f);
    bus_read(`UART_ADR_TX_BDR, w);
    check_word("tx_bdr", w, 32'hdead_0005 & BDR_MASK);
    bus_read(`UART_ADR_RX_BDR, w);
    check_word("rx_bdr", w, 32'h1234_abcd & BDR_MASK);
    bus_read(`UART_ADR_RX_SMP, w);
    check_word("rx_smp", w, 32'hffff_0102 & BDR_MASK);
    bus_read(`UART_ADR_TX_IRQ, w);
    check_word("tx_irq", w, 32'hffff_ffe4 & CNT_MASK);
    bus_read(`UART_ADR_RX_IRQ, w);
    check_word("rx_irq", w, 32'h0000_003f & CNT_MASK);
    // Holes in the map
    bus_read(6'h0c, w);
    check_word("rdt at 0x0c", w, '0);
    bus_read(6'h14, w);
    check_word("rdt at 0x14", w, '0);
    bus_read(6'h3c, w);
    check_word("rdt at 0x3c", w, '0);
    bus_write(`UART_ADR_TX_IRQ, 32'd0);
    bus_write(`UART_ADR_RX_IRQ, 32'd0);
  endtask

  task automatic test_tx_frames();
    uart_dat_t data [T3_FRM];
    bus_dat_t  w;
    for (int i = 0; i < T3_FRM; i++) data[i] = rand_byte();
    bus_write(`UART_ADR_TX_BDR, T3_BDR);
    fork
      begin  // Bus side pushes, line side collects
        for (int i = 0; i < T3_FRM; i++) bus_write(`UART_ADR_TX_DAT, 32'(data[i]));
      end
      begin
        uart_dat_t b;
        for (int i = 0; i < T3_FRM; i++) begin
          recv_frame(T3_BDR + 1, b);
          check_dat("txd frame", b, data[i]);
        end
      end
    join
    bus_read(`UART_ADR_TX_CNT, w);
    check_cnt("tx_cnt", uart_cnt_t'(w), '0);
  endtask

  task automatic test_rx_frames();
    uart_dat_t data [T4_FRM];
    bus_dat_t  w;
    bus_write(`UART_ADR_RX_BDR, RX_BDR);
    bus_write(`UART_ADR_RX_SMP, RX_SMP);
    for (int i = 0; i < T4_FRM; i++) begin
      data[i] = rand_byte();
      send_frame(data[i], RX_BDR + 1);
      poll_rx_level(uart_cnt_t'(i + 1));
    end
    for (int i = 0; i < T4_FRM; i++) begin  // Each read pops the head
      bus_read(`UART_ADR_RX_DAT, w);
      check_dat("rx data", uart_dat_t'(w), data[i]);
    end
    bus_read(`UART_ADR_RX_DAT, w);
    check_word("rx data when empty", w, '0);
    bus_read(`UART_ADR_RX_CNT, w);
    check_cnt("rx_cnt", uart_cnt_t'(w), '0);
  endtask

  task automatic test_tx_overflow();
    uart_dat_t data [T5_WR];
    uart_dat_t rx_data [T5_RX];
    bus_dat_t  w;
    for (int i = 0; i < T5_WR; i++) data[i] = rand_byte();
    bus_write(`UART_ADR_TX_BDR, T5_BDR);
    bus_write(`UART_ADR_TX_IRQ, T5_TXTH);
    fork
      begin
        for (int i = 0; i < T5_WR; i++) bus_write(`UART_ADR_TX_DAT, 32'(data[i]));
        bus_read(`UART_ADR_TX_CNT, w);
        check_cnt("tx_cnt full", uart_cnt_t'(w), `UART_FIFO_SZ);
        check_bit("irq_tx", irq_tx, 1'b0);
      end
      begin
        uart_dat_t b;
        int        lvl;
        for (int k = 1; k <= T5_TX; k++) begin
          recv_frame(T5_BDR + 1, b);
          check_dat("txd frame", b, data[k-1]);
          // Mid stop bit, next byte not yet taken
          lvl = T5_TX - k;
          bus_read(`UART_ADR_TX_CNT, w);
          check_cnt("tx_cnt", uart_cnt_t'(w), uart_cnt_t'(lvl));
          check_bit("irq_tx", irq_tx, lvl < T5_TXTH);
        end
      end
    join
    // Dropped byte must never show up
    repeat (10 * (T5_BDR + 1)) begin
      @(posedge tcb);
      #DRV_DLY;
      if (txd !== 1'b1) abort_run("Extra frame on txd after the FIFO overflowed");
    end
    bus_write(`UART_ADR_RX_IRQ, T5_RXTH);
    for (int k = 1; k <= T5_RX; k++) begin
      rx_data[k-1] = rand_byte();
      send_frame(rx_data[k-1], RX_BDR + 1);
      poll_rx_level(uart_cnt_t'(k));
      check_bit("irq_rx", irq_rx, k > T5_RXTH);
    end
    for (int k = 0; k < T5_RX; k++) begin
      bus_read(`UART_ADR_RX_DAT, w);
      check_dat("rx data", uart_dat_t'(w), rx_data[k]);
    end
    check_bit("irq_rx", irq_rx, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    tcb = 1'b0;
    rst = 1'b1;
    req = '0;
    rxd = 1'b1;  // Line idle
    repeat (4) @(posedge tcb);
    #DRV_DLY;
    rst = 1'b0;
    test_reset_values();
    test_register_access();
    test_tx_frames();
    test_rx_frames();
    test_tx_overflow();
    if (UUT.chk.fail_cnt != 0) begin
      abort_run("Bound checker reported assertion failures");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  initial begin
    #(WDOG_NS);
    abort_run("Timeout, the tests did not finish in the expected run time");
  end

endmodule : uart_ctl_tb

/* testbench/uart_ctl_chk.sv */
// Concurrent assertions on the UART controller top, bound into uart_ctl for simulation
`timescale 1ns/1ps
`include "uart_ctl_defines.svh"

module uart_ctl_chk import uart_pkg::*; (
  input logic      tcb,
  input logic      rst,
  input bus_req_t  req,
  input bus_rsp_t  rsp,
  input logic      txd,
  input logic      irq_tx,
  input uart_cnt_t tx_cnt,
  input uart_cnt_t rx_cnt
);

  int unsigned fail_cnt = 0;  // Assertion failures so far

  logic      rd_req;
  uart_cnt_t tx_thr;  // TX threshold as last written on the bus

  assign rd_req = req.vld & ~req.wen;

  // Threshold follows bus writes, masked to the level width
  always_ff @(posedge tcb) begin
    if (rst) begin
      tx_thr <= uart_cnt_t'(`UART_IRQ_RST);
    end else if (req.vld && req.wen && (req.adr == `UART_ADR_TX_IRQ)) begin
      tx_thr <= req.wdt[`UART_FIFO_CW-1:0];
    end
  end

  // Line idles high out of reset
  a_txd_rst: assert property (@(posedge tcb) rst |=> txd)
    else begin
      $error("txd low after reset");
      fail_cnt++;
    end

  a_lvl_max: assert property (@(posedge tcb) disable iff (rst)
    (tx_cnt <= `UART_FIFO_SZ) && (rx_cnt <= `UART_FIFO_SZ))
    else begin
      $error("FIFO level above depth");
      fail_cnt++;
    end

  // Response valid exactly one cycle after a read
  a_rsp_hit: assert property (@(posedge tcb) disable iff (rst) rd_req |=> rsp.vld)
    else begin
      $error("Read without response");
      fail_cnt++;
    end
  a_rsp_idle: assert property (@(posedge tcb) disable iff (rst) !rd_req |=> !rsp.vld)
    else begin
      $error("Response without read");
      fail_cnt++;
    end

  a_irq_tx: assert property (@(posedge tcb) disable iff (rst) irq_tx == (tx_cnt < tx_thr))
    else begin
      $error("irq_tx does not follow TX level");
      fail_cnt++;
    end

endmodule : uart_ctl_chk

bind uart_ctl uart_ctl_chk chk (
  .tcb, .rst, .req, .rsp, .txd, .irq_tx, .tx_cnt, .rx_cnt
);

/* src/uart_ctl.sv */
// UART controller top, connects register block, TX FIFO and serializer, RX deserializer and FIFO
`timescale 1ns/1ps

module uart_ctl import uart_pkg::*; (
  input  logic     tcb,
  input  logic     rst,
  // Register bus
  input  bus_req_t req,
  output bus_rsp_t rsp,
  // Serial lines
  input  logic     rxd,
  output logic     txd,
  // Interrupts
  output logic     irq_tx,
  output logic     irq_rx
);

  // Register block to FIFO streams
  logic      tx_bus_vld, rx_bus_vld;
  uart_dat_t tx_bus_dat, rx_bus_dat;
  logic      tx_bus_rdy, rx_bus_rdy;
  // FIFO to serializer, deserializer to FIFO
  logic      tx_str_vld, rx_str_vld;
  uart_dat_t tx_str_dat, rx_str_dat;
  logic      tx_str_rdy;
  // Status and configuration
  uart_cnt_t tx_cnt, rx_cnt;
  uart_bdr_t tx_bdr, rx_bdr, rx_smp;

  //////////////////////////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////////////////////////

  uart_regs regs (
    .tcb, .rst, .req, .rsp,
    .tx_vld (tx_bus_vld), .tx_dat (tx_bus_dat), .tx_rdy (tx_bus_rdy),
    .tx_cnt, .tx_bdr,
    .rx_vld (rx_bus_vld), .rx_dat (rx_bus_dat), .rx_rdy (rx_bus_rdy),
    .rx_cnt, .rx_bdr, .rx_smp,
    .irq_tx, .irq_rx
  );

  //////////////////////////////////////////////////////////////////////
  // TX channel
  //////////////////////////////////////////////////////////////////////

  uart_fifo tx_fifo (
    .tcb, .rst,
    .sti_vld (tx_bus_vld), .sti_dat (tx_bus_dat), .sti_rdy (tx_bus_rdy),
    .sto_vld (tx_str_vld), .sto_dat (tx_str_dat), .sto_rdy (tx_str_rdy),
    .cnt     (tx_cnt)
  );

  uart_ser tx_ser (
    .tcb, .rst, .cfg_bdr (tx_bdr),
    .str_vld (tx_str_vld), .str_dat (tx_str_dat), .str_rdy (tx_str_rdy),
    .txd
  );

  //////////////////////////////////////////////////////////////////////
  // RX channel
  //////////////////////////////////////////////////////////////////////

  uart_des rx_des (
    .tcb, .rst, .cfg_bdr (rx_bdr), .cfg_smp (rx_smp),
    .rxd, .str_vld (rx_str_vld), .str_dat (rx_str_dat)
  );

  // Line cannot stall, a byte arriving at a full FIFO is lost
  uart_fifo rx_fifo (
    .tcb, .rst,
    .sti_vld (rx_str_vld), .sti_dat (rx_str_dat), .sti_rdy (),
    .sto_vld (rx_bus_vld), .sto_dat (rx_bus_dat), .sto_rdy (rx_bus_rdy),
    .cnt     (rx_cnt)
  );

endmodule : uart_ctl

/* src/uart_regs.sv */
// UART register block, decodes bus accesses, keeps configuration, moves FIFO data, drives IRQs
`timescale 1ns/1ps
`include "uart_ctl_defines.svh"

module uart_regs import uart_pkg::*; (
  input  logic      tcb,
  input  logic      rst,
  // Register bus
  input  bus_req_t  req,
  output bus_rsp_t  rsp,
  // TX FIFO push side
  output logic      tx_vld,
  output uart_dat_t tx_dat,
  input  logic      tx_rdy,
  input  uart_cnt_t tx_cnt,
  output uart_bdr_t tx_bdr,
  // RX FIFO pop side
  input  logic      rx_vld,
  input  uart_dat_t rx_dat,
  output logic      rx_rdy,
  input  uart_cnt_t rx_cnt,
  output uart_bdr_t rx_bdr,
  output uart_bdr_t rx_smp,
  // Interrupts
  output logic      irq_tx,
  output logic      irq_rx
);

  uart_cnt_t tx_irq;   // TX threshold
  uart_cnt_t rx_irq;   // RX threshold
  logic      wr;
  logic      rd;
  bus_dat_t  rdt;      // Selected read data
  logic      rsp_vld;
  bus_dat_t  rsp_rdt;

  // Always ready, valid alone is a transfer
  assign wr = req.vld &  req.wen;
  assign rd = req.vld & ~req.wen;

  //////////////////////////////////////////////////////////////////////
  // Configuration writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      tx_bdr <= uart_bdr_t'(`UART_BDR_RST);
      tx_irq <= uart_cnt_t'(`UART_IRQ_RST);
      rx_bdr <= uart_bdr_t'(`UART_BDR_RST);
      rx_smp <= uart_bdr_t'(`UART_SMP_RST);
      rx_irq <= uart_cnt_t'(`UART_IRQ_RST);
    end else if (wr) begin
      case (req.adr)
        `UART_ADR_TX_BDR: tx_bdr <= req.wdt[`UART_BW-1:0];       // Upper bits ignored
        `UART_ADR_TX_IRQ: tx_irq <= req.wdt[`UART_FIFO_CW-1:0];
        `UART_ADR_RX_BDR: rx_bdr <= req.wdt[`UART_BW-1:0];
        `UART_ADR_RX_SMP: rx_smp <= req.wdt[`UART_BW-1:0];
        `UART_ADR_RX_IRQ: rx_irq <= req.wdt[`UART_FIFO_CW-1:0];
        default: ;  // Data, status and holes
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FIFO strobes
  //////////////////////////////////////////////////////////////////////

  // Write to TX data pushes, full FIFO drops the byte
  assign tx_vld = wr & (req.adr == `UART_ADR_TX_DAT) & tx_rdy;
  assign tx_dat = req.wdt[`UART_DW-1:0];

  // Read of RX data pops the head
  assign rx_rdy = rd & (req.adr == `UART_ADR_RX_DAT);

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req.adr)
      `UART_ADR_TX_CNT: rdt = 32'(tx_cnt);
      `UART_ADR_TX_BDR: rdt = 32'(tx_bdr);
      `UART_ADR_TX_IRQ: rdt = 32'(tx_irq);
      `UART_ADR_RX_DAT: rdt = rx_vld ? 32'(rx_dat) : '0;  // Empty reads zero
      `UART_ADR_RX_CNT: rdt = 32'(rx_cnt);
      `UART_ADR_RX_BDR: rdt = 32'(rx_bdr);
      `UART_ADR_RX_SMP: rdt = 32'(rx_smp);
      `UART_ADR_RX_IRQ: rdt = 32'(rx_irq);
      default:          rdt = '0;  // TX data and unmapped
    endcase
  end

  // Response one cycle after the read
  always_ff @(posedge tcb) begin
    if (rst) rsp_vld <= 1'b0;
    else     rsp_vld <= rd;
  end

  always_ff @(posedge tcb) begin
    if (rd) rsp_rdt <= rdt;
  end

  assign rsp = '{vld: rsp_vld, rdt: rsp_rdt};

  // Level interrupts
  assign irq_tx = (tx_cnt < tx_irq);  // TX running low
  assign irq_rx = (rx_cnt > rx_irq);  // RX filling up

endmodule : uart_regs

/* src/uart_des.sv */
// UART receiver, finds the start edge on rxd, samples each bit at a set phase, emits characters
`timescale 1ns/1ps
`include "uart_ctl_defines.svh"

module uart_des import uart_pkg::*; (
  input  logic      tcb,
  input  logic      rst,
  input  uart_bdr_t cfg_bdr,  // Cycles per bit, minus one
  input  uart_bdr_t cfg_smp,  // Sample point within a bit
  // Serial line
  input  logic      rxd,
  // Character stream into RX FIFO, no back-pressure
  output logic      str_vld,
  output uart_dat_t str_dat
);

  localparam int unsigned BIT_W = $clog2(`UART_DW);

  logic       [1:0]       rxd_sync;  // Two-flop synchronizer
  logic                   rxd_dly;   // For edge detect
  logic                   rxd_s;
  logic                   fall;
  des_state_t             state;
  uart_bdr_t              bdr_cnt;
  logic       [BIT_W-1:0] bit_cnt;
  uart_dat_t              shr;
  logic                   bdr_end;
  logic                   smp;
  logic                   bit_last;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      rxd_sync <= '1;
      rxd_dly  <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_dly  <= rxd_s;
    end
  end

  assign rxd_s = rxd_sync[1];
  assign fall  = rxd_dly & ~rxd_s;  // Start bit edge

  //////////////////////////////////////////////////////////////////////
  // Bit timing FSM
  //////////////////////////////////////////////////////////////////////

  assign bdr_end  = (bdr_cnt == cfg_bdr);
  assign smp      = (bdr_cnt == cfg_smp);
  assign bit_last = (bit_cnt == BIT_W'(`UART_DW-1));

  always_ff @(posedge tcb) begin
    if (rst) begin
      state   <= DES_IDLE;
      bdr_cnt <= '0;
      bit_cnt <= '0;
      str_vld <= 1'b0;
    end else begin
      str_vld <= 1'b0;  // Single cycle pulse
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
      case (state)
        DES_IDLE: begin
          bdr_cnt <= '0;
          if (fall) state <= DES_START;
        end
        DES_START: begin
          if (smp && rxd_s) begin
            state <= DES_IDLE;  // Glitch, not a start bit
          end else if (bdr_end) begin
            state   <= DES_DATA;
            bit_cnt <= '0;
          end
        end
        DES_DATA: if (bdr_end) begin
          if (bit_last) state <= DES_STOP;
          else          bit_cnt <= bit_cnt + 1'b1;
        end
        DES_STOP: if (smp) begin
          str_vld <= rxd_s;  // Low stop bit drops the frame
          state   <= DES_IDLE;
        end
        default: state <= DES_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge tcb) begin
    if ((state == DES_DATA) && smp) shr <= {rxd_s, shr[`UART_DW-1:1]};
  end

  // Stable until the next frame reaches its data bits
  assign str_dat = shr;

endmodule : uart_des

/* src/uart_ser.sv */
// UART transmitter, frames FIFO characters as start, 8 data bits LSB first and stop on txd
`timescale 1ns/1ps
`include "uart_ctl_defines.svh"

module uart_ser import uart_pkg::*; (
  input  logic      tcb,
  input  logic      rst,
  input  uart_bdr_t cfg_bdr,  // Cycles per bit, minus one
  // Character stream from TX FIFO
  input  logic      str_vld,
  input  uart_dat_t str_dat,
  output logic      str_rdy,
  // Serial line
  output logic      txd
);

  localparam int unsigned BIT_W = $clog2(`UART_DW);

  ser_state_t             state;
  uart_bdr_t              bdr_cnt;  // Cycles within current bit
  logic       [BIT_W-1:0] bit_cnt;  // Data bit index
  uart_dat_t              shr;      // Shift register, LSB goes out next
  logic                   bdr_end;
  logic                   bit_last;
  logic                   take;
  logic                   shift;

  assign str_rdy  = (state == SER_IDLE);
  assign take     = str_vld & str_rdy;
  assign bdr_end  = (bdr_cnt == cfg_bdr);
  assign bit_last = (bit_cnt == BIT_W'(`UART_DW-1));
  // Next data bit moves onto the line
  assign shift    = bdr_end & ((state == SER_START) | ((state == SER_DATA) & ~bit_last));

  always_ff @(posedge tcb) begin
    if (rst) begin
      state   <= SER_IDLE;
      txd     <= 1'b1;  // Line idles high
      bdr_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
      case (state)
        SER_IDLE: begin
          bdr_cnt <= '0;
          if (take) begin
            state <= SER_START;
            txd   <= 1'b0;  // Start bit
          end
        end
        SER_START: if (bdr_end) begin
          state   <= SER_DATA;
          txd     <= shr[0];
          bit_cnt <= '0;
        end
        SER_DATA: if (bdr_end) begin
          if (bit_last) begin
            txd   <= 1'b1;  // Stop bit
            // Last stop cycle is spent in IDLE, so frames stay back to back
            state <= (cfg_bdr == '0) ? SER_IDLE : SER_STOP;
          end else begin
            txd     <= shr[0];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        SER_STOP: if (bdr_cnt == cfg_bdr - 1'b1) state <= SER_IDLE;
        default:  state <= SER_IDLE;
      endcase
    end
  end

  // Payload shift register
  always_ff @(posedge tcb) begin
    if (take)       shr <= str_dat;
    else if (shift) shr <= shr >> 1;
  end

endmodule : uart_ser

/* src/uart_fifo.sv */
// Character FIFO with valid/ready stream ports and a fill counter, used on both UART channels
`timescale 1ns/1ps
`include "uart_ctl_defines.svh"

module uart_fifo import uart_pkg::*; (
  input  logic      tcb,
  input  logic      rst,
  // Input stream
  input  logic      sti_vld,
  input  uart_dat_t sti_dat,
  output logic      sti_rdy,
  // Output stream
  output logic      sto_vld,
  output uart_dat_t sto_dat,
  input  logic      sto_rdy,
  // Fill level
  output uart_cnt_t cnt
);

  localparam int unsigned PW = $clog2(`UART_FIFO_SZ);  // Pointer width

  uart_dat_t         mem [`UART_FIFO_SZ];  // Storage
  logic     [PW-1:0] wr_ptr;
  logic     [PW-1:0] rd_ptr;
  logic              push;
  logic              pop;

  // Handshakes
  assign push = sti_vld & sti_rdy;
  assign pop  = sto_vld & sto_rdy;

  assign sti_rdy = (cnt != uart_cnt_t'(`UART_FIFO_SZ));  // Not full
  assign sto_vld = (cnt != '0);                          // Not empty

  //////////////////////////////////////////////////////////////////////
  // Pointers and counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(`UART_FIFO_SZ-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(`UART_FIFO_SZ-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Level tracks push/pop, unchanged on both
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= sti_dat;
  end

  // Head is visible without a register stage
  assign sto_dat = mem[rd_ptr];

endmodule : uart_fifo

/* src/uart_pkg.sv */
// Shared UART types: data vectors, register bus request/response and FSM state encodings
`include "uart_ctl_defines.svh"

package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [`UART_DW-1:0]      uart_dat_t;  // One character
  typedef logic [`UART_BW-1:0]      uart_bdr_t;  // Cycles per bit, minus one
  typedef logic [`UART_FIFO_CW-1:0] uart_cnt_t;  // FIFO fill level
  typedef logic [`UART_AW-1:0]      bus_adr_t;   // Register byte address
  typedef logic [31:0]              bus_dat_t;   // Bus word

  //////////////////////////////////////////////////////////////////////
  // Register bus
  //////////////////////////////////////////////////////////////////////

  // Request, a transfer on every cycle with vld high
  typedef struct packed {
    logic     vld;  // Request valid
    logic     wen;  // Write enable
    bus_adr_t adr;  // Address
    bus_dat_t wdt;  // Write data
  } bus_req_t;

  // Read response, one cycle after the request
  typedef struct packed {
    logic     vld;  // Response valid
    bus_dat_t rdt;  // Read data
  } bus_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SER_IDLE, SER_START, SER_DATA, SER_STOP
  } ser_state_t;

  typedef enum logic [1:0] {
    DES_IDLE, DES_START, DES_DATA, DES_STOP
  } des_state_t;

endpackage : uart_pkg

/* src/uart_ctl_defines.svh */
// UART controller sizes, register map and reset values, included by the package and the RTL
`ifndef UART_CTL_DEFINES_SVH
`define UART_CTL_DEFINES_SVH

// Character and configuration widths
`define UART_DW       8   // Bits per character
`define UART_BW       16  // Baud and sample phase width

// FIFO sizing
`define UART_FIFO_SZ  16  // Entries per FIFO
`define UART_FIFO_CW  5   // Fill counter width, holds 0..SZ

// Register bus
`define UART_AW       6   // Byte address width

// Register offsets, TX channel
`define UART_ADR_TX_DAT 6'h00  // Push into TX FIFO
`define UART_ADR_TX_CNT 6'h04  // TX fill level
`define UART_ADR_TX_BDR 6'h08  // TX baud period
`define UART_ADR_TX_IRQ 6'h10  // TX level threshold

// Register offsets, RX channel
`define UART_ADR_RX_DAT 6'h20  // Pop from RX FIFO
`define UART_ADR_RX_CNT 6'h24  // RX fill level
`define UART_ADR_RX_BDR 6'h28  // RX baud period
`define UART_ADR_RX_SMP 6'h2C  // RX sample phase
`define UART_ADR_RX_IRQ 6'h30  // RX level threshold

// Reset values
`define UART_BDR_RST  7
`define UART_SMP_RST  3
`define UART_IRQ_RST  0

`endif
